// ==== core_pkg.sv ====
// core package with shared widths, alu codes, operand selects and fetch states
package core_pkg;

    // data, address and instruction word
    typedef logic [31:0] word_t;
    // register index
    typedef logic [4:0] reg_addr_t;
    // alu operation code
    typedef logic [3:0] alu_op_t;
    // operand selects, b field in [3:2] and a field in [1:0]
    typedef logic [3:0] alu_sel_t;
    // immediate format choice
    typedef logic imm_kind_t;

    // alu operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // operand a field values
    localparam logic [1:0] SEL_A_RS1  = 2'd0;
    localparam logic [1:0] SEL_A_PC   = 2'd1;
    localparam logic [1:0] SEL_A_ZERO = 2'd2;
    // operand b field values
    localparam logic [1:0] SEL_B_RS2  = 2'd0;
    localparam logic [1:0] SEL_B_IMM  = 2'd1;
    localparam logic [1:0] SEL_B_FOUR = 2'd2;
    localparam logic [1:0] SEL_B_ZERO = 2'd3;

    localparam imm_kind_t IMM_I = 1'b0;
    localparam imm_kind_t IMM_U = 1'b1;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [1:0] {
        S_ADDR,
        S_DATA,
        S_HALT
    } fetch_state_e;

endpackage

// ==== core_fetch.sv ====
// fetch unit, axi4-lite read master holding the pc and the fetch state machine
`timescale 1ns/100ps

module core_fetch #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // ar channel
    output core_pkg::word_t m_araddr_o,
    output logic [2:0]      m_arprot_o,
    output logic            m_arvalid_o,
    input  logic            m_arready_i,
    // r channel
    input  core_pkg::word_t m_rdata_i,
    input  logic [1:0]      m_rresp_i,
    input  logic            m_rvalid_i,
    output logic            m_rready_o,
    // to execute
    output core_pkg::word_t pc_o,
    output core_pkg::word_t instr_o,
    output logic            instr_valid_o,
    output logic            fault_o
);
    import core_pkg::*;

    // unprivileged, secure, instruction access
    localparam logic [2:0] ARPROT_INSTR = 3'b100;
    localparam logic [1:0] RESP_OKAY    = 2'b00;

    fetch_state_e state_q;
    word_t        pc_q;
    logic         arvalid_q;
    logic         rready_q;
    logic         fault_q;
    logic         r_done;
    logic         r_okay;

    // r handshake this cycle
    assign r_done = rready_q & m_rvalid_i;
    assign r_okay = (m_rresp_i == RESP_OKAY);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= S_ADDR;
            pc_q      <= RESET_PC;
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            fault_q   <= 1'b0;
        end else begin
            case (state_q)
                S_ADDR: begin
                    // only taken on the first cycle out of reset
                    if (!arvalid_q) begin
                        arvalid_q <= 1'b1;
                    end else if (m_arready_i) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state_q   <= S_DATA;
                    end
                end
                S_DATA: begin
                    // rready stays up until rvalid shows
                    if (r_done) begin
                        rready_q <= 1'b0;
                        if (r_okay) begin
                            pc_q      <= pc_q + 32'd4;
                            arvalid_q <= 1'b1;
                            state_q   <= S_ADDR;
                        end else begin
                            // error response, stop for good
                            fault_q <= 1'b1;
                            state_q <= S_HALT;
                        end
                    end
                end
                // sits here until reset
                S_HALT: begin
                    arvalid_q <= 1'b0;
                    rready_q  <= 1'b0;
                end
                default: state_q <= S_HALT;
            endcase
        end
    end

    // address held at pc while arvalid waits for arready
    assign m_araddr_o  = pc_q;
    assign m_arprot_o  = ARPROT_INSTR;
    assign m_arvalid_o = arvalid_q;
    assign m_rready_o  = rready_q;

    // instruction valid for the handshake cycle only
    assign instr_o       = m_rdata_i;
    assign instr_valid_o = r_done & r_okay;
    assign pc_o          = pc_q;
    assign fault_o       = fault_q;

endmodule

// ==== core_decoder.sv ====
// control decoder mapping instruction fields to write enable, alu op and operand selects
`timescale 1ns/100ps

module core_decoder (
    input  core_pkg::word_t     instr_i,
    input  logic                instr_valid_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    output core_pkg::reg_addr_t rd_addr_o,
    output logic                wd_o,
    output core_pkg::imm_kind_t imm_kind_o,
    output core_pkg::alu_op_t   alu_op_o,
    output core_pkg::alu_sel_t  alu_sel_o
);
    import core_pkg::*;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // fixed field positions
    assign rd_addr_o  = instr_i[11:7];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    always_comb begin
        supported  = 1'b0;
        alu_op_o   = ALU_ADD;
        alu_sel_o  = {SEL_B_RS2, SEL_A_RS1};
        imm_kind_o = IMM_I;
        case (opcode)
            OPC_OP: begin
                supported = 1'b1;
                // funct7 and funct3 together pick the op
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: alu_op_o = ALU_ADD;
                    {F7_ALT,  3'b000}: alu_op_o = ALU_SUB;
                    {F7_BASE, 3'b001}: alu_op_o = ALU_SLL;
                    {F7_BASE, 3'b010}: alu_op_o = ALU_SLT;
                    {F7_BASE, 3'b011}: alu_op_o = ALU_SLTU;
                    {F7_BASE, 3'b100}: alu_op_o = ALU_XOR;
                    {F7_BASE, 3'b101}: alu_op_o = ALU_SRL;
                    {F7_ALT,  3'b101}: alu_op_o = ALU_SRA;
                    {F7_BASE, 3'b110}: alu_op_o = ALU_OR;
                    {F7_BASE, 3'b111}: alu_op_o = ALU_AND;
                    default:           supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                supported = 1'b1;
                alu_sel_o = {SEL_B_IMM, SEL_A_RS1};
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    // shifts check the upper immediate bits too
                    3'b001: begin
                        alu_op_o  = ALU_SLL;
                        supported = (funct7 == F7_BASE);
                    end
                    default: begin
                        alu_op_o  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        supported = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                endcase
            end
            // lui is zero plus the u immediate
            OPC_LUI: begin
                supported  = 1'b1;
                imm_kind_o = IMM_U;
                alu_sel_o  = {SEL_B_IMM, SEL_A_ZERO};
            end
            // auipc adds the pc
            OPC_AUIPC: begin
                supported  = 1'b1;
                imm_kind_o = IMM_U;
                alu_sel_o  = {SEL_B_IMM, SEL_A_PC};
            end
            default: supported = 1'b0;
        endcase
    end

    // write only on the accepted cycle
    assign wd_o = supported & instr_valid_i;

endmodule

// ==== core_imm_gen.sv ====
// immediate generator for sign-extended i-type and upper u-type immediates
`timescale 1ns/100ps

module core_imm_gen (
    input  core_pkg::word_t     instr_i,
    input  core_pkg::imm_kind_t imm_kind_i,
    output core_pkg::word_t     imm_o
);
    import core_pkg::*;

    word_t imm_i_type;
    word_t imm_u_type;

    // 12 bits from instr[31:20], sign bit is instr[31]
    // shamt rides along in the low five bits
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};

    // upper 20 bits, low 12 cleared
    assign imm_u_type = {instr_i[31:12], 12'b0};

    assign imm_o = (imm_kind_i == IMM_U) ? imm_u_type : imm_i_type;

endmodule

// ==== core_alu.sv ====
// alu with operand muxing and the ten integer operations
`timescale 1ns/100ps

module core_alu (
    input  core_pkg::word_t    pc_i,
    input  core_pkg::word_t    rs1_data_i,
    input  core_pkg::word_t    rs2_data_i,
    input  core_pkg::word_t    imm_i,
    input  core_pkg::alu_op_t  alu_op_i,
    input  core_pkg::alu_sel_t alu_sel_i,
    output core_pkg::word_t    result_o
);
    import core_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    // operand a from the low select field
    always_comb begin
        case (alu_sel_i[1:0])
            SEL_A_RS1:  op_a = rs1_data_i;
            SEL_A_PC:   op_a = pc_i;
            SEL_A_ZERO: op_a = '0;
            default:    op_a = '0;
        endcase
    end

    // operand b from the high select field
    always_comb begin
        case (alu_sel_i[3:2])
            SEL_B_RS2:  op_b = rs2_data_i;
            SEL_B_IMM:  op_b = imm_i;
            SEL_B_FOUR: op_b = 32'd4;
            SEL_B_ZERO: op_b = '0;
            default:    op_b = '0;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = op_a + op_b;
            ALU_SUB:  result_o = op_a - op_b;
            ALU_SLL:  result_o = op_a << shamt;
            // signed compare
            ALU_SLT:  result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result_o = {31'b0, op_a < op_b};
            ALU_XOR:  result_o = op_a ^ op_b;
            ALU_SRL:  result_o = op_a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result_o = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   result_o = op_a | op_b;
            ALU_AND:  result_o = op_a & op_b;
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== core_regfile.sv ====
// register file with 31 writable registers, x0 tied to zero and three read ports
`timescale 1ns/100ps

module core_regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    input  core_pkg::reg_addr_t rd_addr_i,
    input  core_pkg::reg_addr_t dbg_raddr_i,
    input  logic                we_i,
    input  core_pkg::word_t     wdata_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    output core_pkg::word_t     dbg_rdata_o
);
    import core_pkg::*;

    // no storage for x0
    word_t regs_q [1:31];

    // writes to x0 dropped
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs_q[rd_addr_i] <= wdata_i;
        end
    end

    // shared by all three read ports
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        data = (addr == '0) ? '0 : regs_q[addr];
        return data;
    endfunction

    assign rs1_data_o  = read_port(rs1_addr_i);
    assign rs2_data_o  = read_port(rs2_addr_i);
    // debugger view, same timing as the execute ports
    assign dbg_rdata_o = read_port(dbg_raddr_i);

endmodule

// ==== core_top.sv ====
// rv32i execution core top level with axi4-lite instruction fetch
`timescale 1ns/100ps

module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // axi4-lite read master
    output core_pkg::word_t     m_araddr_o,
    output logic [2:0]          m_arprot_o,
    output logic                m_arvalid_o,
    input  logic                m_arready_i,
    input  core_pkg::word_t     m_rdata_i,
    input  logic [1:0]          m_rresp_i,
    input  logic                m_rvalid_i,
    output logic                m_rready_o,
    // debug register read
    input  core_pkg::reg_addr_t dbg_raddr_i,
    output core_pkg::word_t     dbg_rdata_o,
    output logic                fault_o
);
    import core_pkg::*;

    word_t     pc;
    word_t     instr;
    logic      instr_valid;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      wd;
    imm_kind_t imm_kind;
    alu_op_t   alu_op;
    alu_sel_t  alu_sel;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;

    core_fetch #(
        .RESET_PC (RESET_PC)
    ) i_core_fetch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .m_araddr_o    (m_araddr_o),
        .m_arprot_o    (m_arprot_o),
        .m_arvalid_o   (m_arvalid_o),
        .m_arready_i   (m_arready_i),
        .m_rdata_i     (m_rdata_i),
        .m_rresp_i     (m_rresp_i),
        .m_rvalid_i    (m_rvalid_i),
        .m_rready_o    (m_rready_o),
        .pc_o          (pc),
        .instr_o       (instr),
        .instr_valid_o (instr_valid),
        .fault_o       (fault_o)
    );

    core_decoder i_core_decoder (
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .wd_o          (wd),
        .imm_kind_o    (imm_kind),
        .alu_op_o      (alu_op),
        .alu_sel_o     (alu_sel)
    );

    core_imm_gen i_core_imm_gen (
        .instr_i    (instr),
        .imm_kind_i (imm_kind),
        .imm_o      (imm)
    );

    core_alu i_core_alu (
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .alu_op_i   (alu_op),
        .alu_sel_i  (alu_sel),
        .result_o   (alu_result)
    );

    // write-back lands on the r handshake edge
    core_regfile i_core_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rd_addr_i   (rd_addr),
        .dbg_raddr_i (dbg_raddr_i),
        .we_i        (wd),
        .wdata_i     (alu_result),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .dbg_rdata_o (dbg_rdata_o)
    );

endmodule

// ==== core_tb.sv ====
// directed testbench for the rv32i core with an axi4-lite instruction memory and a reference model
`timescale 1ns/100ps

module core_tb;
    import core_pkg::*;

    localparam word_t TB_RESET_PC = 32'h0000_1000;
    localparam int    CLK_PERIOD  = 4;
    // fetches served by each test
    localparam int    N_RESET = 4;
    localparam int    N_RTYPE = 26;
    localparam int    N_ITYPE = 13;
    localparam int    N_UPPER = 3;
    localparam int    N_NOWR  = 6;
    localparam int    N_FAULT = 2;
    localparam int    N_TOTAL = N_RESET + N_RTYPE + N_ITYPE + N_UPPER + N_NOWR + N_FAULT;

    logic       clk;
    logic       rst_n;
    word_t      araddr;
    logic [2:0] arprot;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    reg_addr_t  dbg_raddr;
    word_t      dbg_rdata;
    logic       fault;

    // instruction memory and per-word error marks
    word_t       imem [0:255];
    logic        imem_err [0:255];
    word_t       load_addr;
    word_t       model_pc;
    word_t       model_regs [0:31];
    logic [15:0] lfsr_q;

    core_top #(
        .RESET_PC (TB_RESET_PC)
    ) i_core_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .m_araddr_o  (araddr),
        .m_arprot_o  (arprot),
        .m_arvalid_o (arvalid),
        .m_arready_i (arready),
        .m_rdata_i   (rdata),
        .m_rresp_i   (rresp),
        .m_rvalid_i  (rvalid),
        .m_rready_o  (rready),
        .dbg_raddr_i (dbg_raddr),
        .dbg_rdata_o (dbg_rdata),
        .fault_o     (fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 64 cycles for every fetch of every test
    initial begin
        #(N_TOTAL * 64 * CLK_PERIOD);
        $display("watchdog expired, the run timed out before all tests finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_equal(input word_t exp, input word_t act, input string msg);
        if (exp !== act) begin
            $display("ERR %0t: %s, expected %h, got %h", $time, msg, exp, act);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
    function automatic word_t lfsr_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                    input reg_addr_t rd);
        return {imm, rd, opc};
    endfunction

    // rv32i integer semantics where alt picks sub or sra
    function automatic word_t ref_op(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    r = (a < b) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // reference model where anything outside the subset writes nothing
    function automatic void model_exec(input word_t instr, input word_t pc);
        logic [6:0] f7;
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       wr;
        f7  = instr[31:25];
        f3  = instr[14:12];
        rd  = instr[11:7];
        a   = model_regs[instr[19:15]];
        b   = model_regs[instr[24:20]];
        wr  = 1'b0;
        res = '0;
        case (instr[6:0])
            OPC_OP: begin
                wr  = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
                res = ref_op(f3, f7 == 7'h20, a, b);
            end
            OPC_OP_IMM: begin
                b = {{20{instr[31]}}, instr[31:20]};
                if (f3 == 3'd1) begin
                    wr = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    wr = (f7 == 7'h00) || (f7 == 7'h20);
                end else begin
                    wr = 1'b1;
                end
                res = ref_op(f3, (f3 == 3'd5) && (f7 == 7'h20), a, b);
            end
            OPC_LUI: begin
                wr  = 1'b1;
                res = {instr[31:12], 12'h000};
            end
            OPC_AUIPC: begin
                wr  = 1'b1;
                res = {instr[31:12], 12'h000} + pc;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            model_regs[rd] = res;
        end
    endfunction

    function automatic void put_instr(input word_t instr);
        word_t off;
        off            = load_addr - TB_RESET_PC;
        imem[off[9:2]] = instr;
        load_addr      = load_addr + 32'd4;
    endfunction

    // lui then addi with the upper part rounded for the sign of the low 12 bits
    function automatic void put_load(input reg_addr_t rd, input word_t value);
        word_t hi;
        hi = value + 32'h0000_0800;
        put_instr(enc_u(OPC_LUI, hi[31:12], rd));
        put_instr(enc_i(value[11:0], 3'd0, rd, rd));
    endfunction

    // one ar and one r transfer with random 0 to 3 cycle gaps
    task automatic serve_fetch(output word_t addr);
        word_t delay;
        word_t off;
        logic  err;
        while (!arvalid) begin
            @(posedge clk);
            #1;
        end
        delay = lfsr_bits(2);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        check_equal(32'd1, word_t'(arvalid), "arvalid dropped before arready");
        check_equal(model_pc, araddr, "fetch address");
        check_equal(32'd4, word_t'(arprot), "arprot not instruction access");
        addr    = araddr;
        arready = 1'b1;
        @(posedge clk);
        #1;
        arready = 1'b0;
        check_equal(32'd1, word_t'(rready), "rready not raised after ar handshake");
        delay   = lfsr_bits(2);
        repeat (delay) begin
            @(posedge clk);
            #1;
            check_equal(32'd1, word_t'(rready), "rready low while waiting for rvalid");
        end
        off    = addr - TB_RESET_PC;
        err    = imem_err[off[9:2]];
        rvalid = 1'b1;
        rdata  = imem[off[9:2]];
        rresp  = err ? 2'b10 : 2'b00;
        @(posedge clk);
        #1;
        rvalid = 1'b0;
        rdata  = '0;
        rresp  = 2'b00;
        if (!err) begin
            model_exec(imem[off[9:2]], addr);
            model_pc = model_pc + 32'd4;
            check_equal(32'd1, word_t'(arvalid), "next arvalid not raised after r handshake");
        end
    endtask

    task automatic run_program(input int n);
        word_t addr;
        repeat (n) begin
            serve_fetch(addr);
        end
    endtask

    task automatic read_reg(input int idx, output word_t value);
        @(posedge clk);
        #1;
        dbg_raddr = reg_addr_t'(idx);
        #1;
        value = dbg_rdata;
    endtask

    task automatic check_all_regs(input string tag);
        word_t value;
        for (int i = 0; i < 32; i++) begin
            read_reg(i, value);
            check_equal(model_regs[i], value, $sformatf("%s x%0d", tag, i));
        end
    endtask

    task automatic test_reset_fetch();
        repeat (16) begin
            @(posedge clk);
            #1;
            check_equal(32'd0, word_t'(arvalid), "arvalid during reset");
            check_equal(32'd0, word_t'(fault), "fault during reset");
        end
        rst_n = 1'b1;
        put_instr(enc_i(12'h011, 3'd0, 5'd1, 5'd0));
        put_instr(enc_i(12'h022, 3'd0, 5'd2, 5'd1));
        put_instr(enc_i(12'h033, 3'd0, 5'd3, 5'd2));
        put_instr(enc_i(12'h044, 3'd0, 5'd4, 5'd3));
        run_program(N_RESET);
        check_all_regs("reset");
    endtask

    task automatic test_rtype();
        // x3 forced negative for the signed cases
        for (int i = 1; i <= 8; i++) begin
            put_load(reg_addr_t'(i), (i == 3) ? (lfsr_bits(32) | 32'h8000_0000) : lfsr_bits(32));
        end
        put_instr(enc_r(7'h00, 3'd0, 5'd10, 5'd1, 5'd2));
        put_instr(enc_r(7'h20, 3'd0, 5'd11, 5'd1, 5'd3));
        put_instr(enc_r(7'h00, 3'd1, 5'd12, 5'd1, 5'd4));
        put_instr(enc_r(7'h00, 3'd2, 5'd13, 5'd3, 5'd1));
        put_instr(enc_r(7'h00, 3'd3, 5'd14, 5'd3, 5'd1));
        put_instr(enc_r(7'h00, 3'd4, 5'd15, 5'd5, 5'd6));
        put_instr(enc_r(7'h00, 3'd5, 5'd16, 5'd3, 5'd4));
        put_instr(enc_r(7'h20, 3'd5, 5'd17, 5'd3, 5'd4));
        put_instr(enc_r(7'h00, 3'd6, 5'd18, 5'd7, 5'd8));
        put_instr(enc_r(7'h00, 3'd7, 5'd19, 5'd7, 5'd8));
        run_program(N_RTYPE);
        check_all_regs("rtype");
    endtask

    task automatic test_itype();
        // 12'h800 is -2048 and 12'hfff is -1
        put_instr(enc_i(12'h800, 3'd0, 5'd20, 5'd1));
        put_instr(enc_i(12'h7ff, 3'd0, 5'd21, 5'd2));
        put_instr(enc_i(12'hfff, 3'd2, 5'd22, 5'd3));
        put_instr(enc_i(12'hfff, 3'd3, 5'd23, 5'd1));
        put_instr(enc_i(12'h800, 3'd4, 5'd24, 5'd3));
        put_instr(enc_i(12'h7ff, 3'd6, 5'd25, 5'd2));
        put_instr(enc_i(12'h800, 3'd7, 5'd26, 5'd3));
        put_instr(enc_i({7'h00, 5'd0}, 3'd1, 5'd27, 5'd1));
        put_instr(enc_i({7'h00, 5'd31}, 3'd1, 5'd28, 5'd1));
        put_instr(enc_i({7'h00, 5'd0}, 3'd5, 5'd29, 5'd3));
        put_instr(enc_i({7'h00, 5'd31}, 3'd5, 5'd30, 5'd3));
        put_instr(enc_i({7'h20, 5'd31}, 3'd5, 5'd31, 5'd3));
        put_instr(enc_i({7'h20, 5'd0}, 3'd5, 5'd9, 5'd3));
        run_program(N_ITYPE);
        check_all_regs("itype");
    endtask

    task automatic test_upper();
        word_t pc_auipc;
        word_t value;
        put_instr(enc_u(OPC_LUI, 20'habcde, 5'd5));
        pc_auipc = load_addr;
        put_instr(enc_u(OPC_AUIPC, 20'h12345, 5'd6));
        put_instr(enc_u(OPC_AUIPC, 20'hfffff, 5'd7));
        run_program(N_UPPER);
        read_reg(5, value);
        check_equal(32'habcd_e000, value, "lui x5");
        read_reg(6, value);
        check_equal(32'h1234_5000 + pc_auipc, value, "auipc x6");
        read_reg(7, value);
        check_equal(32'hffff_f000 + pc_auipc + 32'd4, value, "auipc x7");
        check_all_regs("upper");
    endtask

    task automatic test_no_write();
        word_t value;
        put_instr(enc_i(12'h005, 3'd0, 5'd0, 5'd1));
        put_instr(enc_r(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));
        // store word of x2 at x1 plus 10 with bits 11:7 looking like rd x10
        put_instr({7'h00, 5'd2, 5'd1, 3'd2, 5'd10, 7'b0100011});
        put_instr(enc_r(7'h01, 3'd0, 5'd11, 5'd1, 5'd2));
        put_instr(enc_i({7'h20, 5'd3}, 3'd1, 5'd12, 5'd1));
        put_instr(enc_i({7'h01, 5'd3}, 3'd5, 5'd13, 5'd1));
        run_program(N_NOWR);
        read_reg(0, value);
        check_equal(32'd0, value, "x0 after writes");
        check_all_regs("nowrite");
    endtask

    task automatic test_fetch_error();
        word_t off;
        check_equal(32'd0, word_t'(fault), "fault before error fetch");
        put_instr(enc_i(12'h077, 3'd0, 5'd9, 5'd0));
        off = load_addr - TB_RESET_PC;
        imem_err[off[9:2]] = 1'b1;
        put_instr(enc_i(12'h001, 3'd0, 5'd9, 5'd0));
        run_program(N_FAULT);
        check_equal(32'd1, word_t'(fault), "fault after slverr");
        repeat (50) begin
            @(posedge clk);
            #1;
            check_equal(32'd0, word_t'(arvalid), "arvalid after fault");
            check_equal(32'd1, word_t'(fault), "fault not sticky");
        end
        check_all_regs("fault");
    endtask

    initial begin
        rst_n     = 1'b0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rresp     = 2'b00;
        dbg_raddr = '0;
        lfsr_q    = 16'd87;
        load_addr = TB_RESET_PC;
        model_pc  = TB_RESET_PC;
        for (int i = 0; i < 256; i++) begin
            imem[i]     = '0;
            imem_err[i] = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        test_reset_fetch();
        test_rtype();
        test_itype();
        test_upper();
        test_no_write();
        test_fetch_error();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
core_pkg.sv
core_fetch.sv
core_decoder.sv
core_imm_gen.sv
core_alu.sv
core_regfile.sv
core_top.sv
core_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -f list.f --top-module core_tb -o core_tb \
    && ./obj_dir/core_tb \
    || exit 1
